// ==== Bender.yml ====
package:
  name: start_sprite_control

sources:
  - files:
      - hw/sprite_pkg.sv
      - hw/sprite_rom.sv
      - hw/sprite_position.sv
      - hw/sprite_scan.sv
      - hw/start_sprite_control.sv
  - target: test
    files:
      - test/start_sprite_control_sva.sv
      - test/tb_start_sprite_control.sv

// ==== filelist.f ====
hw/sprite_pkg.sv
hw/sprite_rom.sv
hw/sprite_position.sv
hw/sprite_scan.sv
hw/start_sprite_control.sv
test/start_sprite_control_sva.sv
test/tb_start_sprite_control.sv

// ==== hw/sprite_pkg.sv ====
`default_nettype none

package sprite_pkg;

        // sprite size in pixels
        localparam int sprite_w = 64;
        localparam int sprite_h = 8;

        // pixel index is {row, column}
        localparam int col_bits = $clog2(sprite_w);
        localparam int row_bits = $clog2(sprite_h);

        // screen coordinates
        typedef logic [7:0] coord_x_t;
        typedef logic [6:0] coord_y_t;

        // distance the sprite moves after a paint pass
        typedef logic [6:0] shift_t;

        // 4 bits each of red, green, blue
        typedef logic [11:0] colour_t;

        typedef logic [row_bits+col_bits-1:0] pixel_addr_t;

endpackage

`default_nettype wire

// ==== hw/sprite_position.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_position #(
        parameter sprite_pkg::coord_x_t start_x = 8'd49,
        parameter sprite_pkg::coord_y_t start_y = 7'd48
) (
        input  logic                 clk,
        input  logic                 arst_n,
        input  logic                 draw,
        input  logic                 clear,
        input  logic                 shift_h,
        input  logic                 shift_v,
        input  logic                 load,
        input  sprite_pkg::shift_t   shift_amount,
        input  sprite_pkg::coord_x_t load_x,
        input  sprite_pkg::coord_y_t load_y,
        input  logic                 pass_end,
        output logic                 step,
        output logic                 blank,
        output sprite_pkg::coord_x_t x_pos,
        output sprite_pkg::coord_y_t y_pos
);

        import sprite_pkg::*;

        coord_x_t x_reg;
        coord_y_t y_reg;
        logic     move_h;
        logic     move_v;

        // mode decode, clear beats shift_h beats shift_v
        assign step  = draw & (clear | shift_h | shift_v);
        assign blank = clear;

        // only paint passes move the sprite
        assign move_h = pass_end & ~clear & shift_h;
        assign move_v = pass_end & ~clear & ~shift_h & shift_v;

        // moved origin already seen by a pass that starts right away
        assign x_pos = move_h ? x_reg + coord_x_t'(shift_amount) : x_reg;
        assign y_pos = move_v ? y_reg + shift_amount : y_reg;

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        x_reg <= start_x;
                        y_reg <= start_y;
                end else if (load && !draw) begin
                        x_reg <= load_x;
                        y_reg <= load_y;
                end else begin
                        x_reg <= x_pos;
                        y_reg <= y_pos;
                end
        end

endmodule

`default_nettype wire

// ==== hw/sprite_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_rom (
        input  sprite_pkg::pixel_addr_t pixel_addr,
        output sprite_pkg::colour_t     pixel_colour
);

        import sprite_pkg::*;

        logic [2*sprite_w-1:0] row_codes;
        logic [col_bits-1:0]   col;
        logic [row_bits-1:0]   row;
        logic [col_bits:0]     code_base;
        logic [1:0]            code;

        assign col = pixel_addr[col_bits-1:0];
        assign row = pixel_addr[col_bits +: row_bits];

        // column 0 sits in the top two bits of a row
        assign code_base = {~col, 1'b0};
        assign code      = row_codes[code_base +: 2];

        // "START" in 2-bit palette codes, rows 0 and 7 are empty
        always_comb begin
                case (row)
                        3'd1:    row_codes = 128'h7860_0000_0000_0078_0000_0000_0000_0000;
                        3'd2:    row_codes = 128'h6660_0000_0600_0181_8000_0180_0000_0000;
                        3'd3:    row_codes = 128'h6660_0000_0600_0181_8000_0180_0000_0000;
                        3'd4:    row_codes = 128'h7867_e606_079f_8079_e7e0_79e0_0000_0000;
                        3'd5:    row_codes = 128'h6666_6666_0619_8019_8661_8180_0000_0000;
                        3'd6:    row_codes = 128'h7867_e198_079f_81e1_e799_81e0_0000_0000;
                        default: row_codes = '0;
                endcase
        end

        // palette
        always_comb begin
                case (code)
                        2'd0:    pixel_colour = 12'h000;
                        2'd1:    pixel_colour = 12'h00f;
                        2'd2:    pixel_colour = 12'hff0;
                        default: pixel_colour = 12'hfff;
                endcase
        end

endmodule

`default_nettype wire

// ==== hw/sprite_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_scan (
        input  logic                    clk,
        input  logic                    arst_n,
        input  logic                    step,
        input  logic                    blank,
        input  sprite_pkg::coord_x_t    x_pos,
        input  sprite_pkg::coord_y_t    y_pos,
        input  sprite_pkg::colour_t     pixel_colour,
        output sprite_pkg::pixel_addr_t pixel_addr,
        output sprite_pkg::coord_x_t    x_out,
        output sprite_pkg::coord_y_t    y_out,
        output sprite_pkg::colour_t     colour_out,
        output logic                    complete,
        output sprite_pkg::coord_x_t    posx,
        output sprite_pkg::coord_y_t    posy
);

        import sprite_pkg::*;

        localparam pixel_addr_t last_pixel = pixel_addr_t'(sprite_w * sprite_h - 1);

        pixel_addr_t         pointer;
        logic [col_bits-1:0] col;
        logic [row_bits-1:0] row;
        logic                last;

        assign pixel_addr = pointer;
        assign col        = pointer[col_bits-1:0];
        assign row        = pointer[col_bits +: row_bits];
        assign last       = (pointer == last_pixel);

        // pass pointer, wraps to 0 after the last pixel
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        pointer <= '0;
                end else if (step) begin
                        pointer <= pointer + 1'b1;
                end
        end

        // pixel registers, screen coordinates wrap at their width
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        x_out      <= '0;
                        y_out      <= '0;
                        colour_out <= '0;
                end else if (step) begin
                        x_out      <= x_pos + coord_x_t'(col);
                        y_out      <= y_pos + coord_y_t'(row);
                        colour_out <= blank ? '0 : pixel_colour;
                end
        end

        // single pulse with the last pixel of a pass
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        complete <= 1'b0;
                end else begin
                        complete <= step & last;
                end
        end

        // origin the finished pass was drawn at
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        posx <= '0;
                        posy <= '0;
                end else if (step && last) begin
                        posx <= x_pos;
                        posy <= y_pos;
                end
        end

endmodule

`default_nettype wire

// ==== hw/start_sprite_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module start_sprite_control #(
        parameter sprite_pkg::coord_x_t start_x = 8'd49,
        parameter sprite_pkg::coord_y_t start_y = 7'd48
) (
        input  logic                 clk,
        input  logic                 arst_n,
        input  logic                 draw,
        input  logic                 clear,
        input  logic                 shift_h,
        input  logic                 shift_v,
        input  logic                 load,
        input  sprite_pkg::shift_t   shift_amount,
        input  sprite_pkg::coord_x_t load_x,
        input  sprite_pkg::coord_y_t load_y,
        output sprite_pkg::coord_x_t x_out,
        output sprite_pkg::coord_y_t y_out,
        output sprite_pkg::colour_t  colour_out,
        output logic                 complete,
        output sprite_pkg::coord_x_t posx,
        output sprite_pkg::coord_y_t posy
);

        import sprite_pkg::*;

        logic        step;
        logic        blank;
        coord_x_t    x_pos;
        coord_y_t    y_pos;
        pixel_addr_t pixel_addr;
        colour_t     pixel_colour;

        sprite_position #(
                .start_x (start_x),
                .start_y (start_y)
        ) i_sprite_position (
                .clk          (clk),
                .arst_n       (arst_n),
                .draw         (draw),
                .clear        (clear),
                .shift_h      (shift_h),
                .shift_v      (shift_v),
                .load         (load),
                .shift_amount (shift_amount),
                .load_x       (load_x),
                .load_y       (load_y),
                .pass_end     (complete),
                .step         (step),
                .blank        (blank),
                .x_pos        (x_pos),
                .y_pos        (y_pos)
        );

        sprite_scan i_sprite_scan (
                .clk          (clk),
                .arst_n       (arst_n),
                .step         (step),
                .blank        (blank),
                .x_pos        (x_pos),
                .y_pos        (y_pos),
                .pixel_colour (pixel_colour),
                .pixel_addr   (pixel_addr),
                .x_out        (x_out),
                .y_out        (y_out),
                .colour_out   (colour_out),
                .complete     (complete),
                .posx         (posx),
                .posy         (posy)
        );

        sprite_rom i_sprite_rom (
                .pixel_addr   (pixel_addr),
                .pixel_colour (pixel_colour)
        );

endmodule

`default_nettype wire

// ==== test/start_sprite_control_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module start_sprite_control_sva (
        input logic                 clk,
        input logic                 arst_n,
        input logic                 draw, clear, shift_h, shift_v,
        input sprite_pkg::coord_x_t x_out,
        input sprite_pkg::coord_y_t y_out,
        input sprite_pkg::colour_t  colour_out,
        input logic                 complete
);

        logic step;

        assign step = draw & (clear | shift_h | shift_v);

        complete_pulse: assert property (
                @(posedge clk) disable iff (!arst_n) complete |=> !complete
        ) else $error("complete stayed high for two cycles");

        // no pixel is emitted without a step
        hold_outputs: assert property (
                @(posedge clk) disable iff (!arst_n)
                !step |=> $stable(x_out) && $stable(y_out) && $stable(colour_out)
        ) else $error("pixel outputs changed while step was low");

        complete_after_step: assert property (
                @(posedge clk) disable iff (!arst_n) !step |=> !complete
        ) else $error("complete rose without a pixel being emitted");

endmodule

`default_nettype wire

// ==== test/start_sprite_tests.txt ====
# image rows: row <index> <64 palette codes 0..3, column 0 first>
# commands: load <x> <y> | pass <clear|h|v> <amount> <origin x> <origin y> | idle <cycles>
row 0 0000000000000000000000000000000000000000000000000000000000000000
row 1 1320120000000000000000000000132000000000000000000000000000000000
row 2 1212120000000000001200000001200120000000000120000000000000000000
row 3 1212120000000000001200000001200120000000000120000000000000000000
row 4 1320121332120012001321332000132132133200132132000000000000000000
row 5 1212121212121212001201212000012120121201200120000000000000000000
row 6 1320121332012120001321332001320132132121200132000000000000000000
row 7 0000000000000000000000000000000000000000000000000000000000000000
pass h 0 49 48
pass clear 5 49 48
pass h 20 49 48
pass v 10 69 48
pass clear 3 69 58
idle 5
load 230 124
pass h 40 230 124
pass v 100 14 124
pass h 0 14 96
idle 3
load 0 0
pass clear 0 0 0

// ==== test/tb_start_sprite_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_start_sprite_control;

        import sprite_pkg::*;

        localparam int pixels = sprite_w * sprite_h;

        logic        clk;
        logic        arst_n;
        logic        draw, clear, shift_h, shift_v, load;
        shift_t      shift_amount;
        coord_x_t    load_x, x_out, posx, pos_x, exp_x, exp_posx;
        coord_y_t    load_y, y_out, posy, pos_y, exp_y, exp_posy;
        colour_t     colour_out, exp_colour;
        logic        complete, exp_complete;
        logic [1:0]  image [0:sprite_h-1][0:sprite_w-1];
        int          ptr;
        logic [31:0] lfsr;
        int          limit_cycles;
        // kind 0 load, 1 pass, 2 idle
        int          cmd_kind[$], cmd_a[$], cmd_b[$], cmd_c[$], cmd_d[$];

        start_sprite_control #(
                .start_x (8'd49),
                .start_y (7'd48)
        ) i_start_sprite_control (
                .clk          (clk),
                .arst_n       (arst_n),
                .draw         (draw),
                .clear        (clear),
                .shift_h      (shift_h),
                .shift_v      (shift_v),
                .load         (load),
                .shift_amount (shift_amount),
                .load_x       (load_x),
                .load_y       (load_y),
                .x_out        (x_out),
                .y_out        (y_out),
                .colour_out   (colour_out),
                .complete     (complete),
                .posx         (posx),
                .posy         (posy)
        );

        bind start_sprite_control start_sprite_control_sva i_sva (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
        endfunction

        task automatic random_bits(input int n, output int value);
                value = 0;
                repeat (n) begin
                        value = (value << 1) | lfsr[0];
                        lfsr  = lfsr_next(lfsr);
                end
        endtask

        function automatic colour_t palette(input logic [1:0] code);
                case (code)
                        2'd0:    return 12'h000;
                        2'd1:    return 12'h00f;
                        2'd2:    return 12'hff0;
                        default: return 12'hfff;
                endcase
        endfunction

        task automatic abort_run(input string msg);
                $display("%s", msg);
                $display("tests failed");
                $fatal(1, "%s", msg);
        endtask

        task automatic check_value(input string name, input logic [31:0] got, exp);
                assert (got === exp) else begin
                        $display("error at %0t: %s is 0x%0h, expected 0x%0h",
                                 $time, name, got, exp);
                        $display("tests failed");
                        $fatal(1, "mismatch on %s", name);
                end
        endtask

        task automatic check_outputs();
                check_value("x_out", x_out, exp_x);
                check_value("y_out", y_out, exp_y);
                check_value("colour_out", colour_out, exp_colour);
                check_value("complete", complete, exp_complete);
                check_value("posx", posx, exp_posx);
                check_value("posy", posy, exp_posy);
        endtask

        task automatic advance();
                @(posedge clk);
                #1;
                check_outputs();
        endtask

        // mode 0 clear, 1 shift_h, 2 shift_v, 3 none
        task automatic drive(input logic d, input int mode, amt, input logic l, input int lx, ly);
                draw         = d;
                clear        = (mode == 0);
                shift_h      = (mode == 1);
                shift_v      = (mode == 2);
                load         = l;
                shift_amount = shift_t'(amt);
                load_x       = coord_x_t'(lx);
                load_y       = coord_y_t'(ly);
                exp_complete = 1'b0;
                if (d && mode < 3) begin
                        exp_x      = pos_x + coord_x_t'(ptr % sprite_w);
                        exp_y      = pos_y + coord_y_t'(ptr / sprite_w);
                        exp_colour = (mode == 0) ? 12'h000 :
                                     palette(image[ptr / sprite_w][ptr % sprite_w]);
                        if (ptr == pixels - 1) begin
                                exp_complete = 1'b1;
                                exp_posx     = pos_x;
                                exp_posy     = pos_y;
                        end
                        ptr = (ptr + 1) % pixels;
                end
        endtask

        task automatic run_pass(input int mode, amt, origin_x, origin_y);
                int gap;
                for (int n = 0; n < pixels; n++) begin
                        // pause now and then before every 32nd pixel
                        if (n % 32 == 31) begin
                                random_bits(2, gap);
                                repeat (gap) begin
                                        drive(1'b0, mode, amt, 1'b0, 0, 0);
                                        advance();
                                end
                        end
                        drive(1'b1, mode, amt, 1'b0, 0, 0);
                        advance();
                end
                // mode held through the complete cycle so the move uses it
                drive(1'b0, mode, amt, 1'b0, 0, 0);
                if (mode == 1)
                        pos_x = pos_x + coord_x_t'(amt);
                if (mode == 2)
                        pos_y = pos_y + coord_y_t'(amt);
                advance();
                check_value("posx", posx, origin_x);
                check_value("posy", posy, origin_y);
        endtask

        task automatic read_tests();
                int fd, n, want, idx, a, b, c, d, col, rows;
                logic [8*160-1:0] line;
                logic [8*8-1:0]   kw, tok;
                logic [8*64-1:0]  digits;
                logic [7:0]       ch;
                rows = 0;
                fd = $fopen("test/start_sprite_tests.txt", "r");
                if (fd == 0)
                        abort_run("cannot open test/start_sprite_tests.txt");
                while ($fgets(line, fd) != 0) begin
                        kw  = '0;
                        tok = '0;
                        if ($sscanf(line, "%s", kw) < 1 || kw == "#")
                                continue;
                        if (kw == "row") begin
                                n    = $sscanf(line, "%s %d %s", kw, idx, digits);
                                want = 3;
                                if (idx < 0 || idx >= sprite_h)
                                        abort_run("image row index out of range");
                                for (col = 0; col < sprite_w; col++) begin
                                        ch = digits[8*(sprite_w-1-col) +: 8];
                                        if (ch < "0" || ch > "3")
                                                abort_run("bad palette code in an image row");
                                        image[idx][col] = 2'(ch - "0");
                                end
                                rows++;
                        end else begin
                                b = 0;
                                c = 0;
                                d = 0;
                                if (kw == "load") begin
                                        n    = $sscanf(line, "%s %d %d", kw, a, b);
                                        want = 3;
                                        cmd_kind.push_back(0);
                                end else if (kw == "pass") begin
                                        n    = $sscanf(line, "%s %s %d %d %d", kw, tok, b, c, d);
                                        want = 5;
                                        a    = (tok == "clear") ? 0 : (tok == "h") ? 1 :
                                               (tok == "v") ? 2 : -1;
                                        if (a < 0)
                                                abort_run("unknown pass mode in the test file");
                                        cmd_kind.push_back(1);
                                end else if (kw == "idle") begin
                                        n    = $sscanf(line, "%s %d", kw, a);
                                        want = 2;
                                        cmd_kind.push_back(2);
                                end else begin
                                        abort_run("unknown command in the test file");
                                end
                                cmd_a.push_back(a);
                                cmd_b.push_back(b);
                                cmd_c.push_back(c);
                                cmd_d.push_back(d);
                        end
                        if (n != want)
                                abort_run("malformed line in the test file");
                end
                $fclose(fd);
                if (rows != sprite_h)
                        abort_run("the test file does not hold all eight image rows");
        endtask

        initial begin : watchdog
                wait (limit_cycles > 0);
                repeat (limit_cycles) @(posedge clk);
                abort_run("timeout, the tests did not finish in time");
        end

        initial begin
                int total;
                arst_n       = 1'b0;
                draw         = 1'b0;
                clear        = 1'b0;
                shift_h      = 1'b0;
                shift_v      = 1'b0;
                load         = 1'b0;
                shift_amount = '0;
                load_x       = '0;
                load_y       = '0;
                lfsr         = 32'h370ce389;
                ptr          = 0;
                pos_x        = 8'd49;
                pos_y        = 7'd48;
                exp_x        = '0;
                exp_y        = '0;
                exp_colour   = '0;
                exp_complete = 1'b0;
                exp_posx     = '0;
                exp_posy     = '0;
                read_tests();
                total = 20;
                foreach (cmd_kind[i])
                        total += (cmd_kind[i] == 1) ? 600 : (cmd_kind[i] == 2) ? cmd_a[i] : 1;
                limit_cycles = total;
                repeat (3) @(posedge clk);
                #1;
                arst_n = 1'b1;
                check_outputs();
                foreach (cmd_kind[i]) begin
                        if (cmd_kind[i] == 0) begin
                                drive(1'b0, 3, 0, 1'b1, cmd_a[i], cmd_b[i]);
                                pos_x = coord_x_t'(cmd_a[i]);
                                pos_y = coord_y_t'(cmd_b[i]);
                                advance();
                        end else if (cmd_kind[i] == 1) begin
                                run_pass(cmd_a[i], cmd_b[i], cmd_c[i], cmd_d[i]);
                        end else begin
                                repeat (cmd_a[i]) begin
                                        drive(1'b0, 3, 0, 1'b0, 0, 0);
                                        advance();
                                end
                        end
                end
                $display("all tests passed");
                $finish;
        end

endmodule

`default_nettype wire
